//--- cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [15:0] addr_t;
	typedef logic [9:0] maddr_t;
	typedef logic [31:0] mword_t;
	// three entry points, index 0 in the low bits.
	typedef logic [29:0] dispatch_t;

	typedef enum logic [1:0] {alu_add, alu_sub, alu_sl, alu_sr} alu_op_t;
	typedef enum logic {ai_zero, ai_sb} ai_sel_t;
	typedef enum logic [1:0] {bi_db, bi_ndb, bi_adl, bi_hld} bi_sel_t;
	typedef enum logic [2:0] {db_dl, db_pcl, db_pch, db_sb, db_a, db_p} db_sel_t;
	typedef enum logic [2:0] {sb_alu, sb_sp, sb_x, sb_y, sb_a, sb_db} sb_sel_t;
	typedef enum logic [1:0] {ad_pc, ad_zp, ad_zpa, ad_sp} ad_sel_t;
	typedef enum logic [1:0] {p_none, p_ldc, p_clr, p_set} p_op_t;
	typedef enum logic [1:0] {seq_fetch, seq_next, seq_skip, seq_disp} seq_t;
	typedef enum logic {wr_read, wr_write} wr_t;

	localparam int flag_c = 0;
	localparam int flag_r = 5;

	// microinstruction field positions, lsb of each field.
	localparam int mop_alu_op = 30;
	localparam int mop_alu_c = 29;
	localparam int mop_ai = 28;
	localparam int mop_bi = 26;
	localparam int mop_db = 23;
	localparam int mop_sb = 20;
	localparam int mop_ld_a = 19;
	localparam int mop_ld_x = 18;
	localparam int mop_ld_y = 17;
	localparam int mop_ld_sp = 16;
	localparam int mop_ad = 14;
	localparam int mop_ab_l = 13;
	localparam int mop_ab_h = 12;
	localparam int mop_pc_inc = 11;
	localparam int mop_p_op = 9;
	localparam int mop_wr = 8;
	localparam int mop_seq = 6;
	localparam int mop_ent = 4;
	localparam int mop_pc_ld = 3;

	// microprogram entry points.
	localparam maddr_t mu_fetch = 10'd0;
	localparam maddr_t mu_decode = 10'd1;
	localparam maddr_t mu_sta = 10'd2;
	localparam maddr_t mu_write = 10'd3;
	localparam maddr_t mu_stx = 10'd4;
	localparam maddr_t mu_sty = 10'd5;
	localparam maddr_t mu_lda = 10'd6;
	localparam maddr_t mu_ldx = 10'd7;
	localparam maddr_t mu_ldy = 10'd8;
	localparam maddr_t mu_adc = 10'd9;
	localparam maddr_t mu_wb = 10'd10;
	localparam maddr_t mu_sbc = 10'd11;
	localparam maddr_t mu_asl = 10'd12;
	localparam maddr_t mu_lsr = 10'd13;
	localparam maddr_t mu_wb_sh = 10'd14;
	localparam maddr_t mu_tax = 10'd15;
	localparam maddr_t mu_txa = 10'd16;
	localparam maddr_t mu_clc = 10'd17;
	localparam maddr_t mu_sec = 10'd18;
	localparam maddr_t mu_nop = 10'd19;

endpackage

`default_nettype wire

//--- mop_rom.sv
`timescale 1ns/100ps
`default_nettype none

module mop_rom (
	input logic clk,
	input logic n_reset,
	input cpu_pkg::maddr_t mop_addr,
	output cpu_pkg::mword_t mop
);

	// single field constants, or-ed together per microinstruction.
	localparam cpu_pkg::mword_t f_ab = 32'd3 << cpu_pkg::mop_ab_h;
	localparam cpu_pkg::mword_t f_inc = 32'd1 << cpu_pkg::mop_pc_inc;
	localparam cpu_pkg::mword_t f_alu_c = 32'd1 << cpu_pkg::mop_alu_c;
	localparam cpu_pkg::mword_t f_ld_a = 32'd1 << cpu_pkg::mop_ld_a;
	localparam cpu_pkg::mword_t f_ld_x = 32'd1 << cpu_pkg::mop_ld_x;
	localparam cpu_pkg::mword_t f_ld_y = 32'd1 << cpu_pkg::mop_ld_y;
	localparam cpu_pkg::mword_t f_ent1 = 32'd1 << cpu_pkg::mop_ent;
	localparam cpu_pkg::mword_t f_ent2 = 32'd2 << cpu_pkg::mop_ent;
	localparam cpu_pkg::mword_t f_wr = 32'(cpu_pkg::wr_write) << cpu_pkg::mop_wr;
	localparam cpu_pkg::mword_t f_next = 32'(cpu_pkg::seq_next) << cpu_pkg::mop_seq;
	localparam cpu_pkg::mword_t f_skip = 32'(cpu_pkg::seq_skip) << cpu_pkg::mop_seq;
	localparam cpu_pkg::mword_t f_disp = 32'(cpu_pkg::seq_disp) << cpu_pkg::mop_seq;
	localparam cpu_pkg::mword_t f_ad_zp = 32'(cpu_pkg::ad_zp) << cpu_pkg::mop_ad;
	localparam cpu_pkg::mword_t f_db_a = 32'(cpu_pkg::db_a) << cpu_pkg::mop_db;
	localparam cpu_pkg::mword_t f_db_sb = 32'(cpu_pkg::db_sb) << cpu_pkg::mop_db;
	localparam cpu_pkg::mword_t f_sb_a = 32'(cpu_pkg::sb_a) << cpu_pkg::mop_sb;
	localparam cpu_pkg::mword_t f_sb_x = 32'(cpu_pkg::sb_x) << cpu_pkg::mop_sb;
	localparam cpu_pkg::mword_t f_sb_y = 32'(cpu_pkg::sb_y) << cpu_pkg::mop_sb;
	localparam cpu_pkg::mword_t f_sb_db = 32'(cpu_pkg::sb_db) << cpu_pkg::mop_sb;
	localparam cpu_pkg::mword_t f_ai_sb = 32'(cpu_pkg::ai_sb) << cpu_pkg::mop_ai;
	localparam cpu_pkg::mword_t f_bi_ndb = 32'(cpu_pkg::bi_ndb) << cpu_pkg::mop_bi;
	localparam cpu_pkg::mword_t f_sub = 32'(cpu_pkg::alu_sub) << cpu_pkg::mop_alu_op;
	localparam cpu_pkg::mword_t f_sl = 32'(cpu_pkg::alu_sl) << cpu_pkg::mop_alu_op;
	localparam cpu_pkg::mword_t f_sr = 32'(cpu_pkg::alu_sr) << cpu_pkg::mop_alu_op;
	localparam cpu_pkg::mword_t f_p_ldc = 32'(cpu_pkg::p_ldc) << cpu_pkg::mop_p_op;
	localparam cpu_pkg::mword_t f_p_clr = 32'(cpu_pkg::p_clr) << cpu_pkg::mop_p_op;
	localparam cpu_pkg::mword_t f_p_set = 32'(cpu_pkg::p_set) << cpu_pkg::mop_p_op;

	// opcode fetch, next byte address goes out.
	localparam cpu_pkg::mword_t f_fetch = f_ab | f_inc | f_next;
	localparam cpu_pkg::mword_t f_store = f_ad_zp | f_ab | f_inc | f_disp | f_ent1;
	localparam cpu_pkg::mword_t f_imm = f_ab | f_inc;

	cpu_pkg::mword_t word;

	// an all-zero word is a do-nothing return to fetch.
	always_comb begin
		case (mop_addr)
		cpu_pkg::mu_fetch: word = f_fetch;
		cpu_pkg::mu_decode: word = f_disp;
		cpu_pkg::mu_sta: word = f_store | f_db_a;
		cpu_pkg::mu_write: word = f_wr | f_ab;
		cpu_pkg::mu_stx: word = f_store | f_db_sb | f_sb_x;
		cpu_pkg::mu_sty: word = f_store | f_db_sb | f_sb_y;
		cpu_pkg::mu_lda: word = f_imm | f_sb_db | f_ld_a;
		cpu_pkg::mu_ldx: word = f_imm | f_sb_db | f_ld_x;
		cpu_pkg::mu_ldy: word = f_imm | f_sb_db | f_ld_y;
		cpu_pkg::mu_adc: word = f_imm | f_sb_a | f_ai_sb | f_alu_c | f_next;
		cpu_pkg::mu_wb: word = f_ld_a | f_p_ldc;
		cpu_pkg::mu_sbc:
			word = f_imm | f_sb_a | f_ai_sb | f_alu_c | f_bi_ndb | f_sub | f_disp | f_ent2;
		cpu_pkg::mu_asl: word = f_sb_a | f_ai_sb | f_sl | f_skip;
		cpu_pkg::mu_lsr: word = f_sb_a | f_ai_sb | f_sr | f_next;
		cpu_pkg::mu_wb_sh: word = f_ld_a | f_p_ldc;
		cpu_pkg::mu_tax: word = f_sb_a | f_ld_x;
		cpu_pkg::mu_txa: word = f_sb_x | f_ld_a;
		cpu_pkg::mu_clc: word = f_p_clr;
		cpu_pkg::mu_sec: word = f_p_set;
		default: word = '0;
		endcase
	end

	always_ff @(posedge clk, negedge n_reset) begin
		if (!n_reset)
			mop <= f_fetch;
		else
			mop <= word;
	end

endmodule

`default_nettype wire

//--- dispatch_rom.sv
`timescale 1ns/100ps
`default_nettype none

module dispatch_rom (
	input logic clk,
	input logic n_reset,
	input logic dispatch_en,
	input cpu_pkg::byte_t opcode,
	output cpu_pkg::dispatch_t entry
);

	cpu_pkg::dispatch_t table_out;

	// entry packing is {point 2, point 1, point 0}.
	always_comb begin
		case (opcode)
		8'ha9: table_out = {cpu_pkg::mu_nop, cpu_pkg::mu_nop, cpu_pkg::mu_lda};
		8'ha2: table_out = {cpu_pkg::mu_nop, cpu_pkg::mu_nop, cpu_pkg::mu_ldx};
		8'ha0: table_out = {cpu_pkg::mu_nop, cpu_pkg::mu_nop, cpu_pkg::mu_ldy};
		8'h69: table_out = {cpu_pkg::mu_nop, cpu_pkg::mu_nop, cpu_pkg::mu_adc};
		8'he9: table_out = {cpu_pkg::mu_wb, cpu_pkg::mu_nop, cpu_pkg::mu_sbc};
		8'h0a: table_out = {cpu_pkg::mu_nop, cpu_pkg::mu_nop, cpu_pkg::mu_asl};
		8'h4a: table_out = {cpu_pkg::mu_nop, cpu_pkg::mu_nop, cpu_pkg::mu_lsr};
		8'haa: table_out = {cpu_pkg::mu_nop, cpu_pkg::mu_nop, cpu_pkg::mu_tax};
		8'h8a: table_out = {cpu_pkg::mu_nop, cpu_pkg::mu_nop, cpu_pkg::mu_txa};
		8'h18: table_out = {cpu_pkg::mu_nop, cpu_pkg::mu_nop, cpu_pkg::mu_clc};
		8'h38: table_out = {cpu_pkg::mu_nop, cpu_pkg::mu_nop, cpu_pkg::mu_sec};
		8'h85: table_out = {cpu_pkg::mu_nop, cpu_pkg::mu_write, cpu_pkg::mu_sta};
		8'h86: table_out = {cpu_pkg::mu_nop, cpu_pkg::mu_write, cpu_pkg::mu_stx};
		8'h84: table_out = {cpu_pkg::mu_nop, cpu_pkg::mu_write, cpu_pkg::mu_sty};
		default: table_out = {cpu_pkg::mu_nop, cpu_pkg::mu_nop, cpu_pkg::mu_nop};
		endcase
	end

	always_ff @(posedge clk, negedge n_reset) begin
		if (!n_reset)
			entry <= {cpu_pkg::mu_nop, cpu_pkg::mu_nop, cpu_pkg::mu_nop};
		else if (dispatch_en)
			entry <= table_out;
	end

endmodule

`default_nettype wire

//--- mop_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module mop_sequencer (
	input logic clk,
	input logic n_reset,
	input cpu_pkg::mword_t mop,
	input cpu_pkg::dispatch_t entry,
	output cpu_pkg::maddr_t mop_addr,
	output logic dispatch_en
);

	cpu_pkg::maddr_t succ;
	cpu_pkg::seq_t seq;
	logic [1:0] ent;

	assign seq = cpu_pkg::seq_t'(mop[cpu_pkg::mop_seq +: 2]);
	assign ent = mop[cpu_pkg::mop_ent +: 2];

	always_comb begin
		case (seq)
		cpu_pkg::seq_next: mop_addr = succ;
		cpu_pkg::seq_skip: mop_addr = succ + 10'd1;
		cpu_pkg::seq_disp: begin
			case (ent)
			2'd1: mop_addr = entry[19:10];
			2'd2: mop_addr = entry[29:20];
			default: mop_addr = entry[9:0];
			endcase
		end
		default: mop_addr = '0;
		endcase
	end

	// opcode is on the bus while the fetch word executes.
	always_ff @(posedge clk, negedge n_reset) begin
		if (!n_reset) begin
			succ <= '0;
			dispatch_en <= 1'b0;
		end else begin
			succ <= mop_addr + 10'd1;
			dispatch_en <= mop_addr == '0;
		end
	end

endmodule

`default_nettype wire

//--- cpu_alu.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_alu (
	input logic clk,
	input logic n_reset,
	input cpu_pkg::mword_t mop,
	input cpu_pkg::byte_t sb,
	input cpu_pkg::byte_t db,
	input cpu_pkg::byte_t adl,
	input cpu_pkg::byte_t dl,
	input logic carry_in,
	output cpu_pkg::byte_t alu_out,
	output logic carry_out
);

	cpu_pkg::alu_op_t op;
	cpu_pkg::bi_sel_t bi_sel;
	cpu_pkg::byte_t ai, bi, ai_hold;
	logic use_c, cin, shift_in;
	logic [8:0] sum;

	assign op = cpu_pkg::alu_op_t'(mop[cpu_pkg::mop_alu_op +: 2]);
	assign bi_sel = cpu_pkg::bi_sel_t'(mop[cpu_pkg::mop_bi +: 2]);
	assign use_c = mop[cpu_pkg::mop_alu_c];

	always_comb begin
		ai = (mop[cpu_pkg::mop_ai] == cpu_pkg::ai_sb) ? sb : 8'h00;
		case (bi_sel)
		cpu_pkg::bi_db: bi = db;
		cpu_pkg::bi_ndb: bi = ~db;
		cpu_pkg::bi_adl: bi = adl;
		default: bi = dl;
		endcase
		// held form pairs last cycle's a operand with the latch.
		if (bi_sel == cpu_pkg::bi_hld && mop[cpu_pkg::mop_ai] == cpu_pkg::ai_sb)
			ai = ai_hold;
	end

	// subtract without carry use is a plain two's complement.
	assign cin = use_c ? carry_in : (op == cpu_pkg::alu_sub);
	assign shift_in = use_c & carry_in;
	assign sum = {1'b0, ai} + {1'b0, bi} + {8'h00, cin};

	always_ff @(posedge clk)
		ai_hold <= ai;

	always_ff @(posedge clk, negedge n_reset) begin
		if (!n_reset)
			{carry_out, alu_out} <= '0;
		else begin
			case (op)
			cpu_pkg::alu_sl: {carry_out, alu_out} <= {ai, shift_in};
			cpu_pkg::alu_sr: {carry_out, alu_out} <= {ai[0], shift_in, ai[7:1]};
			default: {carry_out, alu_out} <= sum;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- status_reg.sv
`timescale 1ns/100ps
`default_nettype none

module status_reg (
	input logic clk,
	input logic n_reset,
	input cpu_pkg::mword_t mop,
	input logic carry_out,
	output cpu_pkg::byte_t p
);

	cpu_pkg::p_op_t p_op;
	cpu_pkg::byte_t mask, p_new;

	assign p_op = cpu_pkg::p_op_t'(mop[cpu_pkg::mop_p_op +: 2]);

	always_comb begin
		mask = 8'h00;
		p_new = p;
		case (p_op)
		cpu_pkg::p_ldc: begin
			mask[cpu_pkg::flag_c] = 1'b1;
			p_new[cpu_pkg::flag_c] = carry_out;
		end
		cpu_pkg::p_clr: begin
			mask[cpu_pkg::flag_c] = 1'b1;
			p_new[cpu_pkg::flag_c] = 1'b0;
		end
		cpu_pkg::p_set: begin
			mask[cpu_pkg::flag_c] = 1'b1;
			p_new[cpu_pkg::flag_c] = 1'b1;
		end
		default: begin
			mask = 8'h00;
		end
		endcase
	end

	always_ff @(posedge clk, negedge n_reset) begin
		if (!n_reset) begin
			p <= 8'h00;
			p[cpu_pkg::flag_r] <= 1'b1;
		end else if (p_op != cpu_pkg::p_none) begin
			p <= (p & ~mask) | (p_new & mask);
			p[cpu_pkg::flag_r] <= 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- cpu_datapath.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_datapath #(
	parameter cpu_pkg::addr_t RESET_PC = 16'h0200
) (
	input logic clk,
	input logic n_reset,
	input cpu_pkg::mword_t mop,
	output cpu_pkg::addr_t addr,
	inout wire cpu_pkg::byte_t data,
	output logic rw
);

	cpu_pkg::byte_t a, x, y, sp, p, dl, dout, alu_out;
	cpu_pkg::byte_t db_bus, sb_bus, db_raw, sb_raw;
	cpu_pkg::addr_t pc, pc_next, ad_bus;
	cpu_pkg::db_sel_t db_sel;
	cpu_pkg::sb_sel_t sb_sel;
	logic carry_out;

	assign db_sel = cpu_pkg::db_sel_t'(mop[cpu_pkg::mop_db +: 3]);
	assign sb_sel = cpu_pkg::sb_sel_t'(mop[cpu_pkg::mop_sb +: 3]);

	// each bus borrows only the other's direct sources.
	always_comb begin
		case (db_sel)
		cpu_pkg::db_pcl: db_raw = pc[7:0];
		cpu_pkg::db_pch: db_raw = pc[15:8];
		cpu_pkg::db_a: db_raw = a;
		cpu_pkg::db_p: db_raw = p;
		default: db_raw = dl;
		endcase
		case (sb_sel)
		cpu_pkg::sb_sp: sb_raw = sp;
		cpu_pkg::sb_x: sb_raw = x;
		cpu_pkg::sb_y: sb_raw = y;
		cpu_pkg::sb_a: sb_raw = a;
		default: sb_raw = alu_out;
		endcase
		db_bus = (db_sel == cpu_pkg::db_sb) ? sb_raw : db_raw;
		sb_bus = (sb_sel == cpu_pkg::sb_db) ? db_raw : sb_raw;
	end

	// pc load takes high byte from db, low byte from the latch.
	assign pc_next = (mop[cpu_pkg::mop_pc_ld] ? {db_bus, dl} : pc)
		+ {15'd0, mop[cpu_pkg::mop_pc_inc]};

	always_comb begin
		case (cpu_pkg::ad_sel_t'(mop[cpu_pkg::mop_ad +: 2]))
		cpu_pkg::ad_zp: ad_bus = {8'h00, dl};
		cpu_pkg::ad_zpa: ad_bus = {8'h00, alu_out};
		cpu_pkg::ad_sp: ad_bus = {8'h01, sp};
		default: ad_bus = pc_next;
		endcase
	end

	always_ff @(posedge clk, negedge n_reset) begin
		if (!n_reset) begin
			a <= '0;
			x <= '0;
			y <= '0;
			sp <= '0;
			pc <= RESET_PC;
			addr <= RESET_PC;
		end else begin
			if (mop[cpu_pkg::mop_ld_a])
				a <= sb_bus;
			if (mop[cpu_pkg::mop_ld_x])
				x <= sb_bus;
			if (mop[cpu_pkg::mop_ld_y])
				y <= sb_bus;
			if (mop[cpu_pkg::mop_ld_sp])
				sp <= sb_bus;
			pc <= pc_next;
			if (mop[cpu_pkg::mop_ab_l])
				addr[7:0] <= ad_bus[7:0];
			if (mop[cpu_pkg::mop_ab_h])
				addr[15:8] <= ad_bus[15:8];
		end
	end

	always_ff @(posedge clk) begin
		dl <= data;
		dout <= db_bus;
	end

	assign rw = mop[cpu_pkg::mop_wr] == cpu_pkg::wr_read;
	assign data = rw ? 8'bz : dout;

	cpu_alu u_alu (
		.clk(clk),
		.n_reset(n_reset),
		.mop(mop),
		.sb(sb_bus),
		.db(db_bus),
		.adl(ad_bus[7:0]),
		.dl(dl),
		.carry_in(p[cpu_pkg::flag_c]),
		.alu_out(alu_out),
		.carry_out(carry_out)
	);

	status_reg u_status (
		.clk(clk),
		.n_reset(n_reset),
		.mop(mop),
		.carry_out(carry_out),
		.p(p)
	);

endmodule

`default_nettype wire

//--- cpu.sv
`timescale 1ns/100ps
`default_nettype none

module cpu #(
	parameter cpu_pkg::addr_t RESET_PC = 16'h0200
) (
	input logic clk,
	input logic n_reset,
	output cpu_pkg::addr_t addr,
	inout wire cpu_pkg::byte_t data,
	output logic rw
);

	cpu_pkg::mword_t mop;
	cpu_pkg::maddr_t mop_addr;
	cpu_pkg::dispatch_t entry;
	logic dispatch_en;

	mop_sequencer u_seq (
		.clk(clk),
		.n_reset(n_reset),
		.mop(mop),
		.entry(entry),
		.mop_addr(mop_addr),
		.dispatch_en(dispatch_en)
	);

	mop_rom u_mop_rom (
		.clk(clk),
		.n_reset(n_reset),
		.mop_addr(mop_addr),
		.mop(mop)
	);

	// opcode comes straight off the external data bus.
	dispatch_rom u_dispatch (
		.clk(clk),
		.n_reset(n_reset),
		.dispatch_en(dispatch_en),
		.opcode(data),
		.entry(entry)
	);

	cpu_datapath #(.RESET_PC(RESET_PC)) u_dp (
		.clk(clk),
		.n_reset(n_reset),
		.mop(mop),
		.addr(addr),
		.data(data),
		.rw(rw)
	);

endmodule

`default_nettype wire

//--- cpu_props.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_props (
	input logic clk,
	input logic n_reset,
	input logic rw,
	input cpu_pkg::addr_t addr,
	input cpu_pkg::byte_t data
);

	int fail_count = 0;

	// bus stays in read while reset is held.
	reset_reads: assert property (@(posedge clk) !n_reset |-> rw)
		else begin
			fail_count++;
			$error("rw low while n_reset is low");
		end

	write_data_known: assert property (@(posedge clk) disable iff (!n_reset)
		!rw |-> !$isunknown(data))
		else begin
			fail_count++;
			$error("data unknown in a write cycle");
		end

	addr_known: assert property (@(posedge clk) disable iff (!n_reset)
		!$isunknown(addr))
		else begin
			fail_count++;
			$error("addr unknown after reset");
		end

endmodule

`default_nettype wire

//--- tb_cpu.sv
`timescale 1ns/100ps
`default_nettype none

module tb_cpu;

	localparam cpu_pkg::addr_t reset_pc = 16'h0200;

	logic clk;
	logic n_reset;
	cpu_pkg::addr_t addr;
	wire cpu_pkg::byte_t data;
	logic rw;

	cpu_pkg::byte_t mem [0:65535];

	// reference model state and the test that last set each register.
	cpu_pkg::byte_t m_a, m_x, m_y;
	logic m_c;
	int src_a, src_x, src_y;

	cpu_pkg::addr_t exp_addr [$];
	cpu_pkg::byte_t exp_data [$];
	int exp_test [$];

	integer seed;
	int n_seen;
	int checks [0:4];
	int errors [0:4];
	string names [0:4];

	cpu #(.RESET_PC(reset_pc)) dut0 (
		.clk(clk),
		.n_reset(n_reset),
		.addr(addr),
		.data(data),
		.rw(rw)
	);

	bind cpu_datapath cpu_props props0 (
		.clk(clk),
		.n_reset(n_reset),
		.rw(rw),
		.addr(addr),
		.data(data)
	);

	// memory answers reads combinationally.
	assign data = rw ? mem[addr] : 8'hzz;

	always #5 clk = ~clk;

	always @(posedge clk) begin
		if (n_reset && rw == 1'b0)
			mem[addr] <= data;
	end

	// write cycles sampled mid-cycle.
	always @(negedge clk) begin
		if (n_reset && rw === 1'b0)
			check_write(addr, data);
	end

	function automatic cpu_pkg::byte_t opcode_of(input int kind);
		case (kind)
		0: return 8'ha9;
		1: return 8'ha2;
		2: return 8'ha0;
		3: return 8'h69;
		4: return 8'he9;
		5: return 8'h0a;
		6: return 8'h4a;
		7: return 8'haa;
		8: return 8'h8a;
		9: return 8'h18;
		10: return 8'h38;
		12: return 8'h86;
		13: return 8'h84;
		14: return 8'hea;
		default: return 8'h85;
		endcase
	endfunction

	function automatic bit has_operand(input int kind);
		return kind <= 4 || (kind >= 11 && kind != 14);
	endfunction

	task automatic model_step(input int kind, input cpu_pkg::byte_t opnd);
		cpu_pkg::byte_t operand;
		logic [8:0] sum;
		operand = (kind == 4) ? ~opnd : opnd;
		sum = {1'b0, m_a} + {1'b0, operand} + {8'h00, m_c};
		case (kind)
		0: begin
			m_a = opnd;
			src_a = 1;
		end
		1: begin
			m_x = opnd;
			src_x = 1;
		end
		2: begin
			m_y = opnd;
			src_y = 1;
		end
		3, 4: begin
			m_a = sum[7:0];
			m_c = sum[8];
			src_a = 2;
		end
		5: begin
			m_c = m_a[7];
			m_a = m_a << 1;
			src_a = 3;
		end
		6: begin
			m_c = m_a[0];
			m_a = m_a >> 1;
			src_a = 3;
		end
		7: begin
			m_x = m_a;
			src_x = 1;
		end
		8: begin
			m_a = m_x;
			src_a = 1;
		end
		9: m_c = 1'b0;
		10: m_c = 1'b1;
		11, 15: begin
			exp_addr.push_back({8'h00, opnd});
			exp_data.push_back(m_a);
			exp_test.push_back(src_a);
		end
		12: begin
			exp_addr.push_back({8'h00, opnd});
			exp_data.push_back(m_x);
			exp_test.push_back(src_x);
		end
		13: begin
			exp_addr.push_back({8'h00, opnd});
			exp_data.push_back(m_y);
			exp_test.push_back(src_y);
		end
		default: ;
		endcase
	endtask

	task automatic build_program();
		cpu_pkg::addr_t pc;
		cpu_pkg::byte_t opnd;
		int i;
		int kind;
		// fill bytes end in 2'b11 and decode as nop.
		for (i = 0; i < 65536; i++)
			mem[i] = (i[15:8] ^ i[7:0]) | 8'h03;
		m_a = 8'h00;
		m_x = 8'h00;
		m_y = 8'h00;
		m_c = 1'b0;
		pc = reset_pc;
		// nop, lda, ldx, ldy and clc open the program.
		for (i = 0; i < 65; i++) begin
			if (i == 0)
				kind = 14;
			else if (i < 4)
				kind = i - 1;
			else if (i == 4)
				kind = 9;
			else
				kind = $unsigned($random(seed)) % 16;
			if (kind >= 11 && kind != 14)
				opnd = 8'h10 + $unsigned($random(seed)) % 48;
			else
				opnd = $random(seed);
			mem[pc] = opcode_of(kind);
			pc++;
			if (has_operand(kind)) begin
				mem[pc] = opnd;
				pc++;
			end
			model_step(kind, opnd);
		end
	endtask

	task automatic check_reset_state();
		checks[0]++;
		if (rw !== 1'b1) begin
			$display("error: rw expected 0x1 got 0x%0h", rw);
			errors[0]++;
		end
		if (addr !== reset_pc) begin
			$display("error: addr expected 0x%04h got 0x%04h", reset_pc, addr);
			errors[0]++;
		end
	endtask

	task automatic check_write(input cpu_pkg::addr_t wa, input cpu_pkg::byte_t wd);
		int t;
		if (n_seen >= exp_addr.size()) begin
			$display("write number %0d seen, only %0d were expected",
				n_seen + 1, exp_addr.size());
			errors[4]++;
		end else begin
			t = exp_test[n_seen];
			checks[t]++;
			if (wa !== exp_addr[n_seen]) begin
				$display("error: write %0d addr expected 0x%04h got 0x%04h",
					n_seen, exp_addr[n_seen], wa);
				errors[t]++;
			end
			if (wd !== exp_data[n_seen]) begin
				$display("error: write %0d data expected 0x%02h got 0x%02h",
					n_seen, exp_data[n_seen], wd);
				errors[t]++;
			end
		end
		n_seen++;
	endtask

	task automatic print_test(input int t);
		$display("test %0d %s: %0d checks, %0d errors, %s", t + 1, names[t],
			checks[t], errors[t], (errors[t] == 0) ? "passed" : "failed");
	endtask

	initial begin
		int i;
		int cycles;
		int failed;
		int n_assert;
		clk = 1'b0;
		n_reset = 1'b0;
		names[0] = "reset state";
		names[1] = "loads and transfers";
		names[2] = "arithmetic with carry";
		names[3] = "shifts";
		names[4] = "write count and order";
		seed = 41868;
		n_seen = 0;
		build_program();

		for (i = 0; i < 8; i++) begin
			@(negedge clk);
			check_reset_state();
		end
		@(posedge clk);
		n_reset <= 1'b1;
		@(negedge clk);
		check_reset_state();
		print_test(0);

		cycles = 0;
		while (n_seen < exp_addr.size() && cycles < 4000) begin
			@(posedge clk);
			cycles++;
		end
		checks[4]++;
		if (n_seen < exp_addr.size()) begin
			$display("timeout after %0d cycles, %0d of %0d writes never happened",
				cycles, exp_addr.size() - n_seen, exp_addr.size());
			errors[4]++;
		end
		// idle window to catch extra writes.
		for (i = 0; i < 40; i++)
			@(posedge clk);

		failed = (errors[0] != 0);
		for (i = 1; i < 5; i++) begin
			print_test(i);
			if (errors[i] != 0)
				failed++;
		end
		n_assert = dut0.u_dp.props0.fail_count;
		$display("tests 5, passed %0d, failed %0d, bus assertion failures %0d",
			5 - failed, failed, n_assert);
		if (failed == 0 && n_assert == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
cpu_pkg.sv
mop_rom.sv
dispatch_rom.sv
mop_sequencer.sv
cpu_alu.sv
status_reg.sv
cpu_datapath.sv
cpu.sv
cpu_props.sv
tb_cpu.sv
